// ==== rtl/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  // Cache geometry
  localparam int tag_len    = 22;
  localparam int index_len  = 4;
  localparam int offset_len = 4;
  localparam int num_ways   = 4;
  localparam int num_sets   = 16;
  localparam int line_words = 16;
  localparam int way_len    = 2;

  typedef logic [tag_len-1:0]    tag_t;
  typedef logic [index_len-1:0]  index_t;
  typedef logic [offset_len-1:0] offset_t;
  typedef logic [way_len-1:0]    way_t;
  typedef logic [1:0]            age_t;
  typedef logic [31:0]           word_t;

  // Word address split, top bits first
  typedef struct packed {
    tag_t       tag;
    index_t     index;
    offset_t    offset;
    logic [1:0] byte_sel;
  } addr_t;

  typedef enum logic {
    ST_IDLE,
    ST_MISS
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== rtl/icache_refill_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface icache_refill_if;
  import icache_pkg::*;

  // Line to fetch, held by the controller for the whole burst
  logic    start;
  tag_t    fill_tag;
  index_t  fill_index;
  offset_t fill_offset;
  way_t    fill_way;

  // One strobe per returned word
  logic    wr_en;
  offset_t wr_offset;
  word_t   wr_data;
  logic    done;

  modport ctrl (
    output start, fill_tag, fill_index, fill_offset, fill_way,
    input  done
  );

  modport refill (
    input  start, fill_tag, fill_index, fill_offset,
    output wr_en, wr_offset, wr_data, done
  );

  modport ways (
    input start, fill_tag, fill_index, fill_way,
    input wr_en, wr_offset, wr_data, done
  );

endinterface

`default_nettype wire

// ==== rtl/icache_ways.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_ways (
  input  logic                          clk,
  input  logic                          rst,
  input  icache_pkg::tag_t              lookup_tag,
  input  icache_pkg::index_t            lookup_index,
  input  icache_pkg::offset_t           lookup_offset,
  output logic                          hit,
  output icache_pkg::way_t              hit_way,
  output icache_pkg::word_t             hit_word,
  output logic [icache_pkg::num_ways-1:0] valid_mask,
  icache_refill_if.ways                 rf
);
  import icache_pkg::*;

  tag_t                tag_mem  [num_ways][num_sets];
  word_t               data_mem [num_ways][num_sets][line_words];
  logic [num_ways-1:0] valid    [num_sets];
  logic [num_ways-1:0] match;

  ////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////

  assign valid_mask = valid[lookup_index];

  always_comb
  begin
    for (int w = 0; w < num_ways; w++)
    begin
      match[w] = valid[lookup_index][w] && (tag_mem[w][lookup_index] == lookup_tag);
    end
  end

  assign hit = |match;

  // Lowest matching way; only one can match in practice
  always_comb
  begin
    hit_way = '0;
    for (int w = num_ways - 1; w >= 0; w--)
    begin
      if (match[w])
        hit_way = way_t'(w);
    end
  end

  assign hit_word = data_mem[hit_way][lookup_index][lookup_offset];

  ////////////////////////////////////////////////////////////
  // Refill writes
  ////////////////////////////////////////////////////////////

  // Line is invalid from start until done
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < num_sets; s++)
      begin
        valid[s] <= '0;
      end
    end
    else if (rf.start)
    begin
      valid[rf.fill_index][rf.fill_way] <= 1'b0;
    end
    else if (rf.done)
    begin
      valid[rf.fill_index][rf.fill_way] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rf.done)
      tag_mem[rf.fill_way][rf.fill_index] <= rf.fill_tag;
  end

  always_ff @(posedge clk)
  begin
    if (rf.wr_en)
      data_mem[rf.fill_way][rf.fill_index][rf.wr_offset] <= rf.wr_data;
  end

endmodule

`default_nettype wire

// ==== rtl/icache_lru.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_lru (
  input  logic                            clk,
  input  logic                            rst,
  input  icache_pkg::index_t              index,
  input  logic [icache_pkg::num_ways-1:0] valid_mask,
  output icache_pkg::way_t                victim,
  input  logic                            touch,
  input  icache_pkg::index_t              touch_index,
  input  icache_pkg::way_t                touch_way
);
  import icache_pkg::*;

  age_t age [num_sets][num_ways];
  age_t ref_age;
  way_t oldest;

  // Invalid way first, else the oldest, lowest number on a tie
  always_comb
  begin
    oldest = '0;
    for (int w = 1; w < num_ways; w++)
    begin
      if (age[index][w] > age[index][oldest])
        oldest = way_t'(w);
    end
    victim = oldest;
    for (int w = num_ways - 1; w >= 0; w--)
    begin
      if (!valid_mask[w])
        victim = way_t'(w);
    end
  end

  assign ref_age = age[touch_index][touch_way];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < num_sets; s++)
      begin
        for (int w = 0; w < num_ways; w++)
        begin
          age[s][w] <= '0;
        end
      end
    end
    else if (touch)
    begin
      for (int w = 0; w < num_ways; w++)
      begin
        if (way_t'(w) == touch_way)
          age[touch_index][w] <= '0;
        else if (age[touch_index][w] <= ref_age && age[touch_index][w] != '1)
          age[touch_index][w] <= age[touch_index][w] + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/icache_refill.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_refill (
  input  logic              clk,
  input  logic              rst,
  icache_refill_if.refill   rf,
  output logic              sen,
  output icache_pkg::word_t addr,
  input  icache_pkg::word_t sdata,
  input  logic              data_ok
);
  import icache_pkg::*;

  offset_t cnt;
  offset_t first_offset;
  logic    last;

  // Words arrive in wrapped order starting at the missed word
  assign rf.wr_en     = sen && data_ok;
  assign rf.wr_offset = first_offset + cnt;
  assign rf.wr_data   = sdata;

  assign last    = (cnt == offset_t'(line_words - 1));
  assign rf.done = rf.wr_en && last;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      sen <= 1'b0;
      cnt <= '0;
    end
    else if (rf.start)
    begin
      sen <= 1'b1;
      cnt <= '0;
    end
    else if (rf.wr_en)
    begin
      // cnt wraps back to zero on the last word
      cnt <= cnt + 1'b1;
      if (last)
        sen <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rf.start)
    begin
      first_offset <= rf.fill_offset;
      addr         <= {rf.fill_tag, rf.fill_index, rf.fill_offset, 2'b00};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  icache_pkg::word_t  addr_in,
  input  logic               req,
  output icache_pkg::word_t  ins,
  output logic               ok,
  output logic               miss,
  input  logic               hit,
  input  icache_pkg::way_t   hit_way,
  input  icache_pkg::word_t  hit_word,
  input  icache_pkg::way_t   victim,
  output logic               touch,
  output icache_pkg::index_t touch_index,
  output icache_pkg::way_t   touch_way,
  icache_refill_if.ctrl      rf
);
  import icache_pkg::*;

  ctrl_state_t state;
  addr_t       req_addr;
  logic        hit_req;
  logic        miss_req;

  assign req_addr = addr_in;
  assign miss     = req && !hit;
  assign hit_req  = (state == ST_IDLE) && req && hit;
  assign miss_req = (state == ST_IDLE) && miss;

  ////////////////////////////////////////////////////////////
  // LRU touch on hit, and on the last refill word
  ////////////////////////////////////////////////////////////

  assign touch       = hit_req || ((state == ST_MISS) && rf.done);
  assign touch_index = (state == ST_MISS) ? rf.fill_index : req_addr.index;
  assign touch_way   = (state == ST_MISS) ? rf.fill_way : hit_way;

  ////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state    <= ST_IDLE;
      ok       <= 1'b0;
      rf.start <= 1'b0;
    end
    else
    begin
      ok       <= hit_req;
      rf.start <= miss_req;
      case (state)
        ST_IDLE:
        begin
          if (miss_req)
            state <= ST_MISS;
        end
        ST_MISS:
        begin
          // Held request hits on the next lookup
          if (rf.done)
            state <= ST_IDLE;
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (hit_req)
      ins <= hit_word;
    if (miss_req)
    begin
      rf.fill_tag    <= req_addr.tag;
      rf.fill_index  <= req_addr.index;
      rf.fill_offset <= req_addr.offset;
      rf.fill_way    <= victim;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  logic              clk,
  input  logic              rst,
  input  icache_pkg::word_t addr_in,
  input  logic              req,
  output icache_pkg::word_t ins,
  output logic              ok,
  output logic              miss,
  output logic              sen,
  output icache_pkg::word_t addr,
  input  icache_pkg::word_t sdata,
  input  logic              data_ok
);
  import icache_pkg::*;

  addr_t               req_addr;
  logic                hit;
  way_t                hit_way;
  word_t               hit_word;
  logic [num_ways-1:0] valid_mask;
  way_t                victim;
  logic                touch;
  index_t              touch_index;
  way_t                touch_way;

  assign req_addr = addr_in;

  icache_refill_if refill_bus ();

  icache_ctrl i_icache_ctrl (
    .clk         (clk),
    .rst         (rst),
    .addr_in     (addr_in),
    .req         (req),
    .ins         (ins),
    .ok          (ok),
    .miss        (miss),
    .hit         (hit),
    .hit_way     (hit_way),
    .hit_word    (hit_word),
    .victim      (victim),
    .touch       (touch),
    .touch_index (touch_index),
    .touch_way   (touch_way),
    .rf          (refill_bus.ctrl)
  );

  icache_ways i_icache_ways (
    .clk           (clk),
    .rst           (rst),
    .lookup_tag    (req_addr.tag),
    .lookup_index  (req_addr.index),
    .lookup_offset (req_addr.offset),
    .hit           (hit),
    .hit_way       (hit_way),
    .hit_word      (hit_word),
    .valid_mask    (valid_mask),
    .rf            (refill_bus.ways)
  );

  icache_lru i_icache_lru (
    .clk         (clk),
    .rst         (rst),
    .index       (req_addr.index),
    .valid_mask  (valid_mask),
    .victim      (victim),
    .touch       (touch),
    .touch_index (touch_index),
    .touch_way   (touch_way)
  );

  icache_refill i_icache_refill (
    .clk     (clk),
    .rst     (rst),
    .rf      (refill_bus.refill),
    .sen     (sen),
    .addr    (addr),
    .sdata   (sdata),
    .data_ok (data_ok)
  );

endmodule

`default_nettype wire

// ==== tests/icache_tb_clk.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tb_clk (
  output logic clk
);

  // 100 ns period
  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== tests/icache_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_sva (
  input logic                    clk,
  input logic                    rst,
  input logic                    req,
  input logic                    hit,
  input logic                    done,
  input icache_pkg::ctrl_state_t state
);
  import icache_pkg::*;

  // Partly filled line must stay invisible
  no_hit_during_refill: assert property (@(posedge clk) disable iff (rst)
    (state == ST_MISS) |-> !hit)
    else $error("held request hit while its line was being refilled");

  done_only_in_miss: assert property (@(posedge clk) disable iff (rst)
    done |-> (state == ST_MISS))
    else $error("refill done outside of a miss");

  // Held request finds the new line right after the last word
  line_hits_after_done: assert property (@(posedge clk) disable iff (rst)
    done |=> (req && hit))
    else $error("filled line did not hit the held request");

endmodule

`default_nettype wire

// ==== tests/icache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tb;
  import icache_pkg::*;

  localparam int clk_period   = 100;
  localparam int num_requests = 80;

  logic  clk;
  logic  rst;
  logic  req;
  word_t addr_in;
  word_t ins;
  logic  ok;
  logic  miss;
  logic  sen;
  word_t addr;
  word_t sdata = '0;
  logic  data_ok = 1'b0;

  integer seed = 32'h56db;
  int     errors = 0;
  int     requests = 0;
  int     tests = 0;
  int     bursts = 0;
  int     words = 0;
  word_t  burst_addr;
  int     sent;
  int     gap;
  logic   sen_q;

  // Reference cache state
  logic ref_valid [num_sets][num_ways];
  tag_t ref_tag   [num_sets][num_ways];
  age_t ref_age   [num_sets][num_ways];

  icache_tb_clk i_icache_tb_clk (.clk(clk));

  icache_top i_icache_top (
    .clk     (clk),
    .rst     (rst),
    .addr_in (addr_in),
    .req     (req),
    .ins     (ins),
    .ok      (ok),
    .miss    (miss),
    .sen     (sen),
    .addr    (addr),
    .sdata   (sdata),
    .data_ok (data_ok)
  );

  bind icache_ctrl icache_sva i_icache_sva (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .hit   (hit),
    .done  (rf.done),
    .state (state)
  );

  function automatic word_t word_at(input word_t byte_addr);
    return byte_addr ^ 32'hA5A5_0000;
  endfunction

  function automatic word_t line_addr(input tag_t tag, input index_t idx, input offset_t off);
    return {tag, idx, off, 2'b00};
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  ////////////////////////////////////////////////////////////
  // Memory model with wrapped bursts and random gaps
  ////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (rst)
    begin
      data_ok <= 1'b0;
      sent    <= 0;
      gap     <= 0;
      sen_q   <= 1'b0;
    end
    else
    begin
      sen_q   <= sen;
      data_ok <= 1'b0;
      if (sen && !sen_q)
      begin
        bursts++;
        burst_addr = addr;
      end
      if (sen && sen_q)
        assert (addr == burst_addr) else report_error("addr changed during a burst");
      if (sen && data_ok)
        words++;
      if (sen && sent < line_words)
      begin
        if (gap > 0)
          gap <= gap - 1;
        else
        begin
          data_ok <= 1'b1;
          sdata   <= word_at({addr[31:6], addr[5:2] + sent[3:0], 2'b00});
          sent    <= sent + 1;
          gap     <= $unsigned($random(seed)) % 4;
        end
      end
      else if (!sen)
        sent <= 0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic int pick_victim(input index_t idx);
    int v;
    v = -1;
    for (int w = num_ways - 1; w >= 0; w--)
      if (!ref_valid[idx][w])
        v = w;
    if (v < 0)
    begin
      v = 0;
      for (int w = 1; w < num_ways; w++)
        if (ref_age[idx][w] > ref_age[idx][v])
          v = w;
    end
    return v;
  endfunction

  task automatic age_touch(input index_t idx, input int way);
    age_t pivot;
    pivot = ref_age[idx][way];
    for (int w = 0; w < num_ways; w++)
      if (w != way && ref_age[idx][w] <= pivot && ref_age[idx][w] != 2'd3)
        ref_age[idx][w] = ref_age[idx][w] + 2'd1;
    ref_age[idx][way] = '0;
  endtask

  task automatic model_access(input word_t a, output logic missed);
    index_t idx;
    tag_t   tag;
    int     way;
    idx = a[9:6];
    tag = a[31:10];
    way = -1;
    for (int w = 0; w < num_ways; w++)
      if (ref_valid[idx][w] && ref_tag[idx][w] == tag)
        way = w;
    missed = (way < 0);
    if (missed)
    begin
      way = pick_victim(idx);
      ref_valid[idx][way] = 1'b1;
      ref_tag[idx][way] = tag;
    end
    age_touch(idx, way);
  endtask

  // Sends one request and checks it against memory and the reference model
  task automatic access(input word_t a, output logic missed);
    logic  exp_miss;
    int    bursts_before;
    int    words_before;
    int    cycles;
    word_t expected;
    expected = word_at({a[31:2], 2'b00});
    model_access(a, exp_miss);
    bursts_before = bursts;
    words_before = words;
    @(posedge clk);
    req     <= 1'b1;
    addr_in <= a;
    cycles = 0;
    do
    begin
      @(posedge clk);
      cycles++;
      if (cycles == 1)
        assert (miss == exp_miss)
          else report_error($sformatf("addr %h miss output %0b, expected %0b",
                                      a, miss, exp_miss));
    end
    while (!ok);
    req <= 1'b0;
    requests++;
    missed = (bursts != bursts_before);
    assert (ins == expected)
      else report_error($sformatf("addr %h gave %h, expected %h", a, ins, expected));
    assert (!miss) else report_error($sformatf("miss high with ok for addr %h", a));
    assert (missed == exp_miss)
      else report_error($sformatf("addr %h miss %0b, model says %0b", a, missed, exp_miss));
    if (missed)
    begin
      assert (bursts - bursts_before == 1 && words - words_before == line_words)
        else report_error($sformatf("addr %h bad burst or word count", a));
      assert (burst_addr == {a[31:2], 2'b00})
        else report_error($sformatf("burst addr %h for request %h", burst_addr, a));
    end
    else
      assert (cycles == 2) else report_error($sformatf("hit ok after %0d cycles", cycles));
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests++;
    $display("test %0d, %s: %0d errors", tests, name, errors - errors_before);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_miss();
    logic m;
    assert (!ok && !sen) else report_error("ok or sen high after reset");
    access(32'h0001_2000, m);
    assert (m) else report_error("first request did not miss");
  endtask

  task automatic test_line_hits();
    logic  m;
    word_t a;
    a = 32'h0005_606E;
    access(a, m);
    assert (m) else report_error("cold miss did not refill");
    access(a, m);
    assert (!m) else report_error("repeated request missed");
    for (int w = 0; w < line_words; w++)
    begin
      access({a[31:6], offset_t'(w), 2'b00}, m);
      assert (!m) else report_error($sformatf("word %0d of the line missed", w));
    end
  endtask

  task automatic test_lru_replace();
    logic  m;
    word_t line [5];
    for (int i = 0; i < 5; i++)
      line[i] = line_addr(tag_t'(22'h100 + i), 4'd5, 4'd3);
    for (int i = 0; i < 4; i++)
      access(line[i], m);
    access(line[0], m);
    assert (!m) else report_error("line A missed after D");
    access(line[4], m);
    assert (m) else report_error("line E did not miss");
    // B is the oldest once A was touched again
    access(line[0], m);
    assert (!m) else report_error("line A was evicted by E");
    access(line[2], m);
    assert (!m) else report_error("line C was evicted by E");
    access(line[3], m);
    assert (!m) else report_error("line D was evicted by E");
    access(line[1], m);
    assert (m) else report_error("line B was not evicted by E");
  endtask

  task automatic test_random_stream();
    logic m;
    tag_t tag;
    index_t idx;
    offset_t off;
    for (int i = 0; i < 40; i++)
    begin
      tag = tag_t'(22'h200 + $unsigned($random(seed)) % 6);
      idx = index_t'(8 + $unsigned($random(seed)) % 4);
      off = offset_t'($random(seed));
      access(line_addr(tag, idx, off), m);
    end
  endtask

  initial
  begin
    int errors_before;
    rst     = 1'b1;
    req     = 1'b0;
    addr_in = '0;
    for (int s = 0; s < num_sets; s++)
      for (int w = 0; w < num_ways; w++)
      begin
        ref_valid[s][w] = 1'b0;
        ref_tag[s][w]   = '0;
        ref_age[s][w]   = '0;
      end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    errors_before = errors;
    test_reset_miss();
    finish_test("reset and first miss", errors_before);
    errors_before = errors;
    test_line_hits();
    finish_test("cold miss and line hits", errors_before);
    errors_before = errors;
    test_lru_replace();
    finish_test("LRU replacement", errors_before);
    errors_before = errors;
    test_random_stream();
    finish_test("random stream", errors_before);
    $display("tests %0d, requests %0d, bursts %0d, errors %0d", tests, requests, bursts, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // Watchdog allowing about 200 cycles per request
  initial
  begin
    #(num_requests * 200 * clk_period);
    $display("Timeout: the tests did not finish within %0d requests of 200 cycles", num_requests);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
rtl/icache_pkg.sv
rtl/icache_refill_if.sv
rtl/icache_ways.sv
rtl/icache_lru.sv
rtl/icache_refill.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
tests/icache_tb_clk.sv
tests/icache_sva.sv
tests/icache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module icache_tb -f project.f -o icache_sim
output="$(./obj_dir/icache_sim)"
echo "$output"
grep -q "SIMULATION PASSED" <<< "$output"
